// ==== hw/hpsdr_pkg.sv ====
// Packet constants, board identity constants, command addresses and payload structs

package hpsdr_pkg;

  // FIFO sizing
  localparam int FIFO_DEPTH   = 1024;
  localparam int FIFO_COUNT_W = 11;

  // Packet lengths in bytes
  localparam logic [10:0] EP6_FRAME_LEN = 11'd1032;
  localparam logic [10:0] DISCOVER_LEN  = 11'd60;
  localparam logic [8:0]  SUBFRAME_SAMPLE_BYTES = 9'd504;  // After sync and response

  // Start thresholds
  localparam logic [FIFO_COUNT_W-1:0] EP6_MIN_WORDS = 11'd334;
  localparam logic [FIFO_COUNT_W-1:0] WIDE_SAMPLES  = 11'd512;  // Samples per EP4 frame

  // Board identity reported in the discovery reply
  localparam logic [7:0] VERSION_MAJOR = 8'd73;
  localparam logic [7:0] VERSION_MINOR = 8'd1;
  localparam logic [7:0] BOARD_ID      = 8'h06;
  localparam logic [7:0] NR_RX         = 8'd4;

  // Command addresses
  localparam logic [5:0] CMD_ADDR_RX  = 6'h00;
  localparam logic [5:0] CMD_ADDR_VNA = 6'h09;

  // Transmit request codes
  localparam logic [1:0] REQ_DISCOVER_0 = 2'b10;
  localparam logic [1:0] REQ_DISCOVER_1 = 2'b11;
  localparam logic [1:0] REQ_DATA       = 2'b10;

  // One I/Q sample of one receiver
  typedef struct packed {
    logic [23:0] iq;
    logic        vna_bit;
    logic        last;     // Final receiver of a round
  } sample_word_t;

  // Raw bandscope ADC sample
  typedef logic [11:0] bs_word_t;

  typedef struct packed {
    logic [47:0] mac;
    logic [31:0] static_ip;
  } identity_t;

  // Telemetry for the discovery reply
  typedef struct packed {
    logic [11:0] temperature;
    logic [11:0] fwd_power;
    logic [11:0] rev_power;
    logic [7:0]  dsiq_status;
  } board_status_t;

endpackage

// ==== hw/stream_fifo.sv ====
// First-word-fall-through FIFO with fill count, generic over payload type
`timescale 1ns/1ps

module stream_fifo import hpsdr_pkg::*; #(
  parameter type payload_t = logic [7:0]
) (
  input  logic                    clk,
  input  logic                    discover_rst,
  input  payload_t                wr_data,
  input  logic                    wr_valid,
  input  logic                    rd_pop,
  output payload_t                rd_data,
  output logic                    rd_valid,
  output logic [FIFO_COUNT_W-1:0] count
);

  payload_t mem [FIFO_DEPTH];

  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
  logic                          push;
  logic                          pop;

  assign rd_valid = (count != '0);
  assign push     = wr_valid && (count != FIFO_COUNT_W'(FIFO_DEPTH));  // Full drops the write
  assign pop      = rd_pop && rd_valid;

  // Head word is visible before the pop
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Pointers wrap naturally at the power of two depth
  always_ff @(posedge clk) begin
    if (discover_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (discover_rst) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or both
      endcase
    end
  end

endmodule

// ==== hw/upstream_cmd_regs.sv ====
// Command register decode and the pending discovery latch
`timescale 1ns/1ps

module upstream_cmd_regs import hpsdr_pkg::*; (
  input  logic        clk,
  input  logic        discover_rst,
  input  logic [5:0]  cmd_addr,
  input  logic [31:0] cmd_data,
  input  logic        cmd_rqst,
  input  logic        discover_rqst,
  input  logic        discover_port,
  input  logic        discover_clear,
  output logic [6:0]  bs_reload,
  output logic        vna_mode,
  output logic        discover_pending,
  output logic        discover_sel
);

  logic [6:0] rx_total;

  assign rx_total = {4'b0000, cmd_data[5:3]} + 7'd1;  // Field holds receivers minus one

  always_ff @(posedge clk) begin
    if (discover_rst) begin
      bs_reload <= 7'd1;
      vna_mode  <= 1'b0;
    end else if (cmd_rqst) begin
      case (cmd_addr)
        CMD_ADDR_RX:  bs_reload <= rx_total << cmd_data[25:24];  // Scaled by speed
        CMD_ADDR_VNA: vna_mode  <= cmd_data[23];
        default: begin
        end
      endcase
    end
  end

  // A new request waits until the pending one is granted
  always_ff @(posedge clk) begin
    if (discover_rst) begin
      discover_pending <= 1'b0;
      discover_sel     <= 1'b0;
    end else if (discover_rqst && !discover_pending) begin
      discover_pending <= 1'b1;
      discover_sel     <= discover_port;
    end else if (discover_clear) begin
      discover_pending <= 1'b0;
    end
  end

endmodule

// ==== hw/upstream_packer.sv ====
// Frame FSM emitting discovery, EP6 and EP4 payload bytes
`timescale 1ns/1ps

module upstream_packer import hpsdr_pkg::*; (
  input  logic                    clk,
  input  logic                    discover_rst,
  input  logic                    have_ip,
  input  logic                    run,
  input  logic                    wide_spectrum,
  input  identity_t               identity,
  input  board_status_t           status,
  input  logic [6:0]              bs_reload,
  input  logic                    vna_mode,
  input  logic                    discover_pending,
  input  logic                    discover_sel,
  input  logic                    udp_tx_enable,
  input  sample_word_t            sample_head,
  input  logic [FIFO_COUNT_W-1:0] sample_count,
  input  bs_word_t                bs_head,
  input  logic [FIFO_COUNT_W-1:0] bs_count,
  input  logic [39:0]             resp,
  input  logic                    stall_req,
  output logic                    discover_clear,
  output logic [1:0]              udp_tx_request,
  output logic [7:0]              udp_tx_data,
  output logic [10:0]             udp_tx_length,
  output logic                    sample_pop,
  output logic                    bs_pop,
  output logic                    resp_rqst,
  output logic                    stall_ack,
  output logic                    watchdog_up
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_DISC_GRANT,
    S_DISC_BODY,
    S_WIDE_GRANT,
    S_WIDE_HDR,
    S_WIDE_LO,
    S_WIDE_HI,
    S_DATA_GRANT,
    S_DATA_HDR,
    S_SYNC_RESP,
    S_IQ2,
    S_IQ1,
    S_IQ0,
    S_MIC1,
    S_MIC0,
    S_PAD
  } state_t;

  state_t      state;
  state_t      after_sub;
  logic [10:0] byte_no;      // Bytes still to come after the one being loaded
  logic [8:0]  round_bytes;
  logic [19:0] ep6_seq;
  logic [19:0] ep4_seq;
  logic [6:0]  wide_cnt;     // EP6 frames until the next wide frame
  logic [7:0]  tx_byte;
  logic        round_vna;
  logic [5:0]  disc_idx;
  logic [8:0]  sub_pos;
  logic        sub_end;

  // Shared EP4/EP6 header after the leading EF
  function automatic logic [7:0] hdr_byte(input logic [2:0]  pos,
                                          input logic [7:0]  ep,
                                          input logic [19:0] seq);
    case (pos)
      3'd6:    return 8'hfe;
      3'd5:    return 8'h01;
      3'd4:    return ep;
      3'd2:    return {4'h0, seq[19:16]};
      3'd1:    return seq[15:8];
      3'd0:    return seq[7:0];
      default: return 8'h00;  // Top byte of the sequence
    endcase
  endfunction

  assign udp_tx_data = tx_byte;
  assign disc_idx    = 6'(DISCOVER_LEN - 11'd1 - byte_no);
  assign sub_pos     = byte_no[8:0] - SUBFRAME_SAMPLE_BYTES;  // 7 down to 0 over sync/resp
  assign sub_end     = (byte_no[8:0] == 9'd0);
  assign after_sub   = byte_no[9] ? S_SYNC_RESP : S_IDLE;

  always_comb begin
    case (state)
      S_DISC_GRANT:               udp_tx_request = discover_sel ? REQ_DISCOVER_1 : REQ_DISCOVER_0;
      S_DATA_GRANT, S_WIDE_GRANT: udp_tx_request = REQ_DATA;
      default:                    udp_tx_request = 2'b00;
    endcase
  end

  assign discover_clear = (state == S_DISC_GRANT) && udp_tx_enable;
  assign stall_ack      = (state == S_IDLE) && stall_req;
  assign sample_pop     = (state == S_IQ0);
  assign bs_pop         = (state == S_WIDE_HI);

  always_ff @(posedge clk) begin
    if (discover_rst) begin
      state         <= S_IDLE;
      byte_no       <= '0;
      round_bytes   <= '0;
      ep6_seq       <= '0;
      ep4_seq       <= '0;
      wide_cnt      <= '0;
      tx_byte       <= '0;
      round_vna     <= 1'b0;
      udp_tx_length <= '0;
      resp_rqst     <= 1'b0;
      watchdog_up   <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (stall_req) begin
            ep6_seq <= '0;
          end else if (discover_pending) begin
            udp_tx_length <= DISCOVER_LEN;
            state         <= S_DISC_GRANT;
          end else if (run && have_ip && (sample_count >= EP6_MIN_WORDS)) begin
            udp_tx_length <= EP6_FRAME_LEN;
            state         <= S_DATA_GRANT;
          end else if ((wide_cnt == '0) && (bs_count >= WIDE_SAMPLES)) begin
            wide_cnt      <= bs_reload;
            watchdog_up   <= ~watchdog_up;
            udp_tx_length <= EP6_FRAME_LEN;
            if (wide_spectrum) begin
              state <= S_WIDE_GRANT;
            end
          end
        end

        S_DISC_GRANT: begin
          byte_no <= DISCOVER_LEN - 11'd2;
          tx_byte <= 8'hef;
          if (udp_tx_enable) begin
            state <= S_DISC_BODY;
          end
        end

        S_DISC_BODY: begin
          byte_no <= byte_no - 11'd1;
          case (disc_idx)
            6'd1:    tx_byte <= 8'hfe;
            6'd2:    tx_byte <= run ? 8'h03 : 8'h02;
            6'd3:    tx_byte <= identity.mac[47:40];
            6'd4:    tx_byte <= identity.mac[39:32];
            6'd5:    tx_byte <= identity.mac[31:24];
            6'd6:    tx_byte <= identity.mac[23:16];
            6'd7:    tx_byte <= identity.mac[15:8];
            6'd8:    tx_byte <= identity.mac[7:0];
            6'd9:    tx_byte <= VERSION_MAJOR;
            6'd10:   tx_byte <= BOARD_ID;
            6'd11:   tx_byte <= identity.static_ip[31:24];
            6'd12:   tx_byte <= identity.static_ip[23:16];
            6'd13:   tx_byte <= identity.static_ip[15:8];
            6'd14:   tx_byte <= identity.static_ip[7:0];
            6'd15:   tx_byte <= NR_RX;
            6'd16:   tx_byte <= VERSION_MINOR;
            6'd17:   tx_byte <= {4'h0, status.temperature[11:8]};
            6'd18:   tx_byte <= status.temperature[7:0];
            6'd19:   tx_byte <= {4'h0, status.fwd_power[11:8]};
            6'd20:   tx_byte <= status.fwd_power[7:0];
            6'd21:   tx_byte <= {4'h0, status.rev_power[11:8]};
            6'd22:   tx_byte <= status.rev_power[7:0];
            6'd23:   tx_byte <= status.dsiq_status;
            default: tx_byte <= 8'h00;
          endcase
          if (byte_no == '0) begin
            state <= S_IDLE;
          end
        end

        S_WIDE_GRANT: begin
          byte_no <= EP6_FRAME_LEN - 11'd2;
          tx_byte <= 8'hef;
          if (udp_tx_enable) begin
            state <= S_WIDE_HDR;
          end
        end

        S_WIDE_HDR: begin
          byte_no <= byte_no - 11'd1;
          tx_byte <= hdr_byte(byte_no[2:0], 8'h04, ep4_seq);
          if (byte_no[2:0] == 3'd0) begin
            ep4_seq <= ep4_seq + 20'd1;
            state   <= S_WIDE_LO;
          end
        end

        S_WIDE_LO: begin
          byte_no <= byte_no - 11'd1;
          tx_byte <= {bs_head[3:0], 4'h0};
          state   <= S_WIDE_HI;
        end

        S_WIDE_HI: begin
          byte_no <= byte_no - 11'd1;
          tx_byte <= bs_head[11:4];
          state   <= (byte_no == '0) ? S_IDLE : S_WIDE_LO;
        end

        S_DATA_GRANT: begin
          byte_no <= EP6_FRAME_LEN - 11'd2;
          tx_byte <= 8'hef;
          if (udp_tx_enable) begin
            state <= S_DATA_HDR;
          end
        end

        S_DATA_HDR: begin
          byte_no <= byte_no - 11'd1;
          tx_byte <= hdr_byte(byte_no[2:0], 8'h06, ep6_seq);
          if (byte_no[2:0] == 3'd0) begin
            ep6_seq <= ep6_seq + 20'd1;
            if (wide_cnt != '0) begin
              wide_cnt <= wide_cnt - 7'd1;
            end
            state <= S_SYNC_RESP;
          end
        end

        S_SYNC_RESP: begin
          byte_no     <= byte_no - 11'd1;
          round_bytes <= '0;
          case (sub_pos)
            9'd4: tx_byte <= resp[39:32];
            9'd3: tx_byte <= resp[31:24];
            9'd2: tx_byte <= resp[23:16];
            9'd1: tx_byte <= resp[15:8];
            9'd0: begin
              tx_byte   <= resp[7:0];
              resp_rqst <= ~resp_rqst;
              state     <= S_IQ2;
            end
            default: tx_byte <= 8'h7f;  // Sync
          endcase
        end

        S_IQ2: begin
          byte_no     <= byte_no - 11'd1;
          round_bytes <= round_bytes + 9'd1;
          tx_byte     <= sample_head.iq[23:16];
          if (round_bytes == '0) begin
            round_vna <= sample_head.vna_bit;  // First word of the round
          end
          state <= sub_end ? after_sub : S_IQ1;
        end

        S_IQ1: begin
          byte_no     <= byte_no - 11'd1;
          round_bytes <= round_bytes + 9'd1;
          tx_byte     <= sample_head.iq[15:8];
          state       <= sub_end ? after_sub : S_IQ0;
        end

        S_IQ0: begin
          byte_no     <= byte_no - 11'd1;
          round_bytes <= round_bytes + 9'd1;
          tx_byte     <= sample_head.iq[7:0];
          if (sub_end) begin
            state <= after_sub;
          end else begin
            state <= sample_head.last ? S_MIC1 : S_IQ2;
          end
        end

        S_MIC1: begin
          byte_no     <= byte_no - 11'd1;
          round_bytes <= round_bytes + 9'd1;
          tx_byte     <= 8'h00;  // No codec
          state       <= sub_end ? after_sub : S_MIC0;
        end

        S_MIC0: begin
          byte_no     <= byte_no - 11'd1;
          round_bytes <= '0;
          tx_byte     <= vna_mode ? {7'h00, round_vna} : 8'h00;
          if (sub_end) begin
            state <= after_sub;
          end else if (byte_no[8:0] > round_bytes) begin
            state <= S_IQ2;  // Room for one more round
          end else begin
            state <= S_PAD;
          end
        end

        S_PAD: begin
          byte_no <= byte_no - 11'd1;
          tx_byte <= 8'h00;
          if (sub_end) begin
            state <= after_sub;
          end
        end

        default: state <= S_IDLE;
      endcase

      if (!run) begin
        ep6_seq <= '0;
        ep4_seq <= '0;
      end
    end
  end

endmodule

// ==== hw/hpsdr_upstream.sv ====
// Upstream top level with sample and bandscope FIFOs, command registers and packer
`timescale 1ns/1ps

module hpsdr_upstream import hpsdr_pkg::*; (
  input  logic          clk,
  input  logic          discover_rst,
  input  logic          have_ip,
  input  logic          run,
  input  logic          wide_spectrum,
  input  identity_t     identity,
  input  board_status_t status,
  input  logic          discover_rqst,
  input  logic          discover_port,
  input  logic [5:0]    cmd_addr,
  input  logic [31:0]   cmd_data,
  input  logic          cmd_rqst,
  input  logic [39:0]   resp,
  output logic          resp_rqst,
  input  sample_word_t  sample_in,
  input  logic          sample_valid,
  input  bs_word_t      bs_in,
  input  logic          bs_valid,
  input  logic          udp_tx_enable,
  output logic [1:0]    udp_tx_request,
  output logic [7:0]    udp_tx_data,
  output logic [10:0]   udp_tx_length,
  input  logic          stall_req,
  output logic          stall_ack,
  output logic          watchdog_up
);

  sample_word_t            sample_head;
  logic [FIFO_COUNT_W-1:0] sample_count;
  logic                    sample_pop;
  bs_word_t                bs_head;
  logic [FIFO_COUNT_W-1:0] bs_count;
  logic                    bs_pop;
  logic [6:0]              bs_reload;
  logic                    vna_mode;
  logic                    discover_pending;
  logic                    discover_sel;
  logic                    discover_clear;

  stream_fifo #(.payload_t(sample_word_t)) sample_fifo_i (
    .clk          (clk),
    .discover_rst (discover_rst),
    .wr_data      (sample_in),
    .wr_valid     (sample_valid),
    .rd_pop       (sample_pop),
    .rd_data      (sample_head),
    .rd_valid     (),
    .count        (sample_count)
  );

  stream_fifo #(.payload_t(bs_word_t)) bs_fifo_i (
    .clk          (clk),
    .discover_rst (discover_rst),
    .wr_data      (bs_in),
    .wr_valid     (bs_valid),
    .rd_pop       (bs_pop),
    .rd_data      (bs_head),
    .rd_valid     (),
    .count        (bs_count)
  );

  upstream_cmd_regs cmd_regs_i (
    .clk              (clk),
    .discover_rst     (discover_rst),
    .cmd_addr         (cmd_addr),
    .cmd_data         (cmd_data),
    .cmd_rqst         (cmd_rqst),
    .discover_rqst    (discover_rqst),
    .discover_port    (discover_port),
    .discover_clear   (discover_clear),
    .bs_reload        (bs_reload),
    .vna_mode         (vna_mode),
    .discover_pending (discover_pending),
    .discover_sel     (discover_sel)
  );

  upstream_packer packer_i (
    .clk              (clk),
    .discover_rst     (discover_rst),
    .have_ip          (have_ip),
    .run              (run),
    .wide_spectrum    (wide_spectrum),
    .identity         (identity),
    .status           (status),
    .bs_reload        (bs_reload),
    .vna_mode         (vna_mode),
    .discover_pending (discover_pending),
    .discover_sel     (discover_sel),
    .udp_tx_enable    (udp_tx_enable),
    .sample_head      (sample_head),
    .sample_count     (sample_count),
    .bs_head          (bs_head),
    .bs_count         (bs_count),
    .resp             (resp),
    .stall_req        (stall_req),
    .discover_clear   (discover_clear),
    .udp_tx_request   (udp_tx_request),
    .udp_tx_data      (udp_tx_data),
    .udp_tx_length    (udp_tx_length),
    .sample_pop       (sample_pop),
    .bs_pop           (bs_pop),
    .resp_rqst        (resp_rqst),
    .stall_ack        (stall_ack),
    .watchdog_up      (watchdog_up)
  );

endmodule

// ==== tb/frame_model.svh ====
// Reference builders for expected discovery, EP6 and EP4 byte sequences
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

// EF FE 01 ep 00, then the 20 bit sequence in three bytes
function automatic void put_header(input logic [7:0] ep, input logic [19:0] seq);
  exp_bytes[0] = 8'hef;
  exp_bytes[1] = 8'hfe;
  exp_bytes[2] = 8'h01;
  exp_bytes[3] = ep;
  exp_bytes[4] = 8'h00;
  exp_bytes[5] = {4'h0, seq[19:16]};
  exp_bytes[6] = seq[15:8];
  exp_bytes[7] = seq[7:0];
endfunction

function automatic void build_discovery(input logic run_lvl, input identity_t id,
                                        input board_status_t st);
  for (int i = 0; i < 60; i++) begin
    exp_bytes[i] = 8'h00;
  end
  exp_bytes[0] = 8'hef;
  exp_bytes[1] = 8'hfe;
  exp_bytes[2] = run_lvl ? 8'h03 : 8'h02;
  for (int i = 0; i < 6; i++) begin
    exp_bytes[3 + i] = id.mac[(5 - i) * 8 +: 8];  // MAC most significant first
  end
  exp_bytes[9] = VERSION_MAJOR;
  exp_bytes[10] = BOARD_ID;
  for (int i = 0; i < 4; i++) begin
    exp_bytes[11 + i] = id.static_ip[(3 - i) * 8 +: 8];
  end
  exp_bytes[15] = NR_RX;
  exp_bytes[16] = VERSION_MINOR;
  exp_bytes[17] = {4'h0, st.temperature[11:8]};
  exp_bytes[18] = st.temperature[7:0];
  exp_bytes[19] = {4'h0, st.fwd_power[11:8]};
  exp_bytes[20] = st.fwd_power[7:0];
  exp_bytes[21] = {4'h0, st.rev_power[11:8]};
  exp_bytes[22] = st.rev_power[7:0];
  exp_bytes[23] = st.dsiq_status;
endfunction

// Consumes whole rounds from the pushed word queue
function automatic void build_ep6(input logic [19:0] seq, input int rx_n, input logic vna,
                                  input logic [39:0] rsp);
  int           pos;
  int           rounds;
  logic         vbit;
  sample_word_t w;
  put_header(8'h06, seq);
  rounds = 504 / (3 * rx_n + 2);
  for (int sub = 0; sub < 2; sub++) begin
    pos = 8 + sub * 512;
    for (int k = 0; k < 3; k++) begin
      exp_bytes[pos + k] = 8'h7f;  // Sync
    end
    for (int k = 0; k < 5; k++) begin
      exp_bytes[pos + 3 + k] = rsp[(4 - k) * 8 +: 8];
    end
    pos = pos + 8;
    for (int r = 0; r < rounds; r++) begin
      vbit = sent_q[0].vna_bit;
      for (int x = 0; x < rx_n; x++) begin
        w = sent_q.pop_front();
        exp_bytes[pos] = w.iq[23:16];
        exp_bytes[pos + 1] = w.iq[15:8];
        exp_bytes[pos + 2] = w.iq[7:0];
        pos = pos + 3;
      end
      exp_bytes[pos] = 8'h00;
      exp_bytes[pos + 1] = vna ? {7'h00, vbit} : 8'h00;
      pos = pos + 2;
    end
    while (pos < 8 + (sub + 1) * 512) begin
      exp_bytes[pos] = 8'h00;  // Pad
      pos = pos + 1;
    end
  end
endfunction

function automatic void build_ep4(input logic [19:0] seq);
  bs_word_t s;
  put_header(8'h04, seq);
  for (int i = 0; i < 512; i++) begin
    s = bs_q.pop_front();
    exp_bytes[8 + 2 * i] = {s[3:0], 4'h0};
    exp_bytes[9 + 2 * i] = s[11:4];
  end
endfunction

`endif

// ==== tb/hpsdr_upstream_tb.sv ====
// Testbench for the upstream packer with byte capture and reference comparison
`timescale 1ns/1ps

module hpsdr_upstream_tb import hpsdr_pkg::*; ();

  localparam int          TIMEOUT_CYCLES = 40000;
  localparam logic [39:0] RESP_VAL       = 40'h12_3456_789a;

  logic clk, discover_rst, have_ip, run, wide_spectrum;
  identity_t identity;
  board_status_t status;
  logic discover_rqst, discover_port, cmd_rqst, resp_rqst;
  logic [5:0] cmd_addr;
  logic [31:0] cmd_data;
  logic [39:0] resp;
  sample_word_t sample_in;
  logic sample_valid, bs_valid, udp_tx_enable, stall_req, stall_ack, watchdog_up;
  bs_word_t bs_in;
  logic [1:0] udp_tx_request;
  logic [7:0] udp_tx_data;
  logic [10:0] udp_tx_length;

  logic [7:0]   exp_bytes [0:1031];
  logic [7:0]   cap_bytes [0:1031];
  logic [1:0]   cap_req;
  logic [10:0]  cap_len;
  sample_word_t sent_q [$];
  bs_word_t     bs_q [$];
  int pkt_count = 0, pkt_target = 0, cycles = 0;
  int resp_toggles = 0, last_toggles = 0, nrx = 2, rx_idx = 0;
  logic prev_resp = 1'b0;
  logic [31:0] lcg_state = 32'h88f07abc;

  `include "frame_model.svh"

  hpsdr_upstream dut_i (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check(input string name, input logic [63:0] expected, input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1, "Mismatch");
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $fatal(1, "Timeout");
    end
  end

  always @(negedge clk) begin
    if (resp_rqst !== prev_resp) begin
      if (!discover_rst) resp_toggles++;  // Reset clear is not a toggle
      prev_resp = resp_rqst;
    end
  end

  // Grants one cycle after a request, then records the payload
  initial begin : capture
    forever begin
      @(negedge clk);
      if (!discover_rst && udp_tx_request != 2'b00) begin
        cap_req = udp_tx_request;
        cap_len = udp_tx_length;
        @(posedge clk) udp_tx_enable <= 1'b1;
        @(posedge clk) udp_tx_enable <= 1'b0;
        for (int i = 0; i < cap_len; i++) begin
          @(negedge clk);
          cap_bytes[i] = udp_tx_data;
        end
        pkt_count++;
      end
    end
  end

  task automatic apply_reset(input int rx_n);
    @(posedge clk) discover_rst <= 1'b1;
    repeat (3) @(posedge clk);
    discover_rst <= 1'b0;
    sent_q.delete();
    bs_q.delete();
    rx_idx = 0;
    nrx = rx_n;
  endtask

  task automatic push_samples(input int n);
    sample_word_t w;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      lcg_state = lcg_next(lcg_state);
      w.iq = lcg_state[31:8];
      w.vna_bit = lcg_state[5];
      w.last = (rx_idx == nrx - 1);
      sample_in <= w;
      sample_valid <= 1'b1;
      sent_q.push_back(w);
      rx_idx = w.last ? 0 : rx_idx + 1;
    end
    @(posedge clk) sample_valid <= 1'b0;
  endtask

  task automatic push_bs(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      lcg_state = lcg_next(lcg_state);
      bs_in <= lcg_state[27:16];
      bs_valid <= 1'b1;
      bs_q.push_back(lcg_state[27:16]);
    end
    @(posedge clk) bs_valid <= 1'b0;
  endtask

  task automatic send_cmd(input logic [5:0] addr, input logic [31:0] data);
    @(posedge clk);
    cmd_addr <= addr;
    cmd_data <= data;
    cmd_rqst <= 1'b1;
    @(posedge clk) cmd_rqst <= 1'b0;
  endtask

  task automatic compare_packet(input string name, input int len, input logic [1:0] req);
    pkt_target++;
    wait (pkt_count == pkt_target);
    check({name, " length"}, len, cap_len);
    check({name, " request"}, req, cap_req);
    for (int i = 0; i < len; i++) begin
      check($sformatf("%s byte %0d", name, i), exp_bytes[i], cap_bytes[i]);
    end
  endtask

  task automatic discovery_test(input string name, input logic port);
    @(posedge clk);
    discover_rqst <= 1'b1;
    discover_port <= port;
    @(posedge clk) discover_rqst <= 1'b0;
    build_discovery(run, identity, status);
    compare_packet(name, 60, port ? REQ_DISCOVER_1 : REQ_DISCOVER_0);
  endtask

  task automatic ep6_test(input string name, input logic [19:0] seq, input logic vna);
    build_ep6(seq, nrx, vna, RESP_VAL);
    compare_packet(name, 1032, REQ_DATA);
    check({name, " resp_rqst toggles"}, 2, resp_toggles - last_toggles);
    last_toggles = resp_toggles;
  endtask

  task automatic ep4_test(input string name, input logic [19:0] seq, input logic wd);
    build_ep4(seq);
    compare_packet(name, 1032, REQ_DATA);
    check({name, " watchdog_up"}, wd, watchdog_up);
  endtask

  initial begin
    discover_rst = 1'b1;
    have_ip = 1'b1;
    run = 1'b0;
    wide_spectrum = 1'b0;
    identity.mac = 48'h001c_c0a2_135d;
    identity.static_ip = 32'hc0a8_0164;
    status.temperature = 12'h9a3;
    status.fwd_power = 12'h1b7;
    status.rev_power = 12'h05c;
    status.dsiq_status = 8'h5a;
    discover_rqst = 1'b0;
    discover_port = 1'b0;
    cmd_addr = '0;
    cmd_data = '0;
    cmd_rqst = 1'b0;
    resp = RESP_VAL;
    sample_in = '0;
    sample_valid = 1'b0;
    bs_in = '0;
    bs_valid = 1'b0;
    udp_tx_enable = 1'b0;
    stall_req = 1'b0;
    repeat (3) @(posedge clk);
    discover_rst <= 1'b0;
    repeat (4) @(negedge clk);
    check("idle request", 0, udp_tx_request);
    check("idle stall_ack", 0, stall_ack);
    check("idle resp_rqst", 0, resp_rqst);
    check("idle watchdog_up", 0, watchdog_up);

    discovery_test("discovery run low", 1'b1);
    @(posedge clk) run <= 1'b1;
    discovery_test("discovery run high", 1'b0);

    // Two receivers, R = 8
    push_samples(334);
    ep6_test("ep6 2rx seq0", 0, 1'b0);
    push_samples(252);
    ep6_test("ep6 2rx seq1", 1, 1'b0);

    send_cmd(CMD_ADDR_VNA, 32'h0080_0000);
    push_samples(252);
    ep6_test("ep6 vna on", 2, 1'b1);
    send_cmd(CMD_ADDR_VNA, 32'h0000_0000);
    push_samples(252);
    ep6_test("ep6 vna off", 3, 1'b0);

    // Three receivers, R = 11 with padding
    apply_reset(3);
    push_samples(334);
    ep6_test("ep6 3rx seq0", 0, 1'b0);
    push_samples(270);
    ep6_test("ep6 3rx seq1", 1, 1'b0);

    // Reload of 2 from two receivers at speed 0
    apply_reset(2);
    @(posedge clk) wide_spectrum <= 1'b1;
    send_cmd(CMD_ADDR_RX, 32'h0000_0008);
    push_bs(1024);
    ep4_test("ep4 seq0", 0, 1'b1);
    push_samples(334);
    ep6_test("wide ep6 seq0", 0, 1'b0);
    push_samples(252);
    ep6_test("wide ep6 seq1", 1, 1'b0);
    ep4_test("ep4 seq1", 1, 1'b0);
    push_samples(252);
    ep6_test("wide ep6 seq2", 2, 1'b0);

    @(posedge clk) stall_req <= 1'b1;
    @(negedge clk);
    check("stall_ack raised", 1, stall_ack);
    push_samples(252);
    repeat (40) begin
      @(negedge clk);
      check("stall request", 0, udp_tx_request);
      check("stall_ack held", 1, stall_ack);
    end
    @(posedge clk) stall_req <= 1'b0;
    ep6_test("ep6 after stall", 0, 1'b0);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== hpsdr_upstream.f ====
+incdir+tb
hw/hpsdr_pkg.sv
hw/stream_fifo.sv
hw/upstream_cmd_regs.sv
hw/upstream_packer.sv
hw/hpsdr_upstream.sv
tb/hpsdr_upstream_tb.sv
